//--- src/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and instruction word width
`define CPU_DATA_WIDTH 16

// eight architectural registers
`define CPU_REG_ADDR_WIDTH 3

// 64 words each
`define CPU_IMEM_ADDR_WIDTH 6
`define CPU_DMEM_ADDR_WIDTH 6

// signed immediate of the I-format
`define CPU_IMM_WIDTH 6

`endif

//--- src/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_WIDTH-1:0]      word_t;
  typedef logic [`CPU_REG_ADDR_WIDTH-1:0]  reg_addr_t;
  typedef logic [`CPU_IMEM_ADDR_WIDTH-1:0] pc_t;

  // codes 8 to 15 fall through to nop
  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_alu  = 4'h1,
    op_addi = 4'h2,
    op_lw   = 4'h3,
    op_sw   = 4'h4,
    op_beq  = 4'h5,
    op_bne  = 4'h6,
    op_halt = 4'h7
  } opcode_e;

  // doubles as the R-format funct field
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5
  } alu_op_e;

  //////////////////////////////
  // instruction word
  //////////////////////////////
  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    alu_op_e   funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e                          opcode;
    reg_addr_t                        rs;
    reg_addr_t                        rt;
    logic signed [`CPU_IMM_WIDTH-1:0] imm6;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  //////////////////////////////
  // pipeline registers
  //////////////////////////////
  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    beq;
    logic    bne;
    logic    halt;
    logic    valid;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    // pc + 1, base of the branch target
    pc_t       pc_next;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm;
    reg_addr_t dest;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu;
    word_t     store_data;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu;
    word_t     load_data;
    reg_addr_t dest;
  } mem_wb_t;

  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_e;

  // one entry per retired register write
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } wb_trace_t;

endpackage

//--- src/control_unit.sv
`timescale 1ns/10ps

module control_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  cpu_pkg::instr_u    instr,
  input  cpu_pkg::id_ex_t    id_ex,
  input  cpu_pkg::ex_mem_t   ex_mem,
  input  cpu_pkg::mem_wb_t   mem_wb,
  input  logic               branch_taken,
  output cpu_pkg::ctrl_t     ctrl,
  output cpu_pkg::reg_addr_t dest,
  output logic               stall,
  output logic               flush,
  output cpu_pkg::fwd_sel_e  fwd_a,
  output cpu_pkg::fwd_sel_e  fwd_b
);

  //////////////////////////////
  // opcode decode
  //////////////////////////////
  always_comb begin
    ctrl       = '0;
    ctrl.valid = 1'b1;
    dest       = '0;
    case (instr.r.opcode)
      cpu_pkg::op_alu: begin
        ctrl.alu_op    = instr.r.funct;
        ctrl.reg_write = 1'b1;
        dest           = instr.r.rd;
      end
      cpu_pkg::op_addi: begin
        ctrl.alu_op      = cpu_pkg::alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        dest             = instr.i.rt;
      end
      cpu_pkg::op_lw: begin
        ctrl.alu_op      = cpu_pkg::alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        dest             = instr.i.rt;
      end
      cpu_pkg::op_sw: begin
        ctrl.alu_op      = cpu_pkg::alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      cpu_pkg::op_beq: ctrl.beq = 1'b1;
      cpu_pkg::op_bne: ctrl.bne = 1'b1;
      cpu_pkg::op_halt: ctrl.halt = 1'b1;
      // everything else moves down the pipe as a nop
      default: ;
    endcase
  end

  //////////////////////////////
  // hazards
  //////////////////////////////

  // load in execute feeding the word in decode
  assign stall = id_ex.ctrl.valid && id_ex.ctrl.mem_read && (id_ex.dest != '0) &&
                 ((id_ex.dest == instr.r.rs) || (id_ex.dest == instr.i.rt));

  // the two younger words die when execute redirects
  assign flush = branch_taken;

  // youngest writer wins
  function automatic cpu_pkg::fwd_sel_e pick_fwd(input cpu_pkg::reg_addr_t src);
    if (ex_mem.ctrl.valid && ex_mem.ctrl.reg_write &&
        (ex_mem.dest != '0) && (ex_mem.dest == src)) begin
      return cpu_pkg::fwd_ex_mem;
    end
    if (mem_wb.ctrl.valid && mem_wb.ctrl.reg_write &&
        (mem_wb.dest != '0) && (mem_wb.dest == src)) begin
      return cpu_pkg::fwd_mem_wb;
    end
    return cpu_pkg::fwd_none;
  endfunction

  always_comb begin
    fwd_a = pick_fwd(id_ex.rs);
    fwd_b = pick_fwd(id_ex.rt);
  end

  // a load-use bubble never lands on a slot that a branch is killing
  a_flush_no_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    flush |-> !stall
  );

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/10ps

`include "cpu_cfg.svh"

module fetch_stage (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            run,
  input  logic            load_we,
  input  cpu_pkg::pc_t    load_addr,
  input  cpu_pkg::word_t  load_data,
  input  logic            stall,
  input  logic            flush,
  input  logic            stop,
  input  logic            branch_taken,
  input  cpu_pkg::pc_t    branch_target,
  output cpu_pkg::instr_u instr,
  output cpu_pkg::pc_t    pc_next,
  output logic            instr_valid
);

  cpu_pkg::pc_t   pc;
  cpu_pkg::word_t imem [2**`CPU_IMEM_ADDR_WIDTH];
  logic           stopped;
  logic           fetch_en;

  // program load, idle core only
  always_ff @(posedge clk) begin
    if (load_we && !run) begin
      imem[load_addr] <= load_data;
    end
  end

  // nothing new once a halt sits in decode
  assign fetch_en = run && !stopped && !stop;

  //////////////////////////////
  // program counter
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= '0;
      stopped <= 1'b0;
    end else begin
      if (branch_taken) begin
        pc <= branch_target;
      end else if (fetch_en && !stall) begin
        pc <= pc + 1'b1;
      end
      // a halt killed by an older branch must not stop fetch
      if (stop && !stall && !flush) begin
        stopped <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr       <= '0;
      pc_next     <= '0;
      instr_valid <= 1'b0;
    end else if (flush) begin
      instr       <= '0;
      instr_valid <= 1'b0;
    end else if (!stall) begin
      // empty slot reads as opcode 0
      instr       <= fetch_en ? imem[pc] : '0;
      pc_next     <= pc + 1'b1;
      instr_valid <= fetch_en;
    end
  end

endmodule

//--- src/register_file.sv
`timescale 1ns/10ps

`include "cpu_cfg.svh"

module register_file (
  input  logic               clk,
  input  logic               arst_n,
  input  cpu_pkg::reg_addr_t rs,
  input  cpu_pkg::reg_addr_t rt,
  input  cpu_pkg::mem_wb_t   wb,
  input  cpu_pkg::word_t     wb_data,
  output cpu_pkg::word_t     rs_data,
  output cpu_pkg::word_t     rt_data
);

  cpu_pkg::word_t regs [2**`CPU_REG_ADDR_WIDTH];
  logic           wr_en;

  // r0 is never written
  assign wr_en = wb.ctrl.valid && wb.ctrl.reg_write && (wb.dest != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**`CPU_REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.dest] <= wb_data;
    end
  end

  // writeback in the same cycle goes straight through
  assign rs_data = (wr_en && (wb.dest == rs)) ? wb_data : regs[rs];
  assign rt_data = (wr_en && (wb.dest == rt)) ? wb_data : regs[rt];

  a_r0_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    (rs == '0) |-> (rs_data == '0)
  );

endmodule

//--- src/execute_stage.sv
`timescale 1ns/10ps

`include "cpu_cfg.svh"

module execute_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  cpu_pkg::id_ex_t   id_in,
  input  logic              stall,
  input  logic              flush,
  input  cpu_pkg::fwd_sel_e fwd_a,
  input  cpu_pkg::fwd_sel_e fwd_b,
  input  cpu_pkg::word_t    wb_data,
  output cpu_pkg::id_ex_t   id_ex,
  output cpu_pkg::ex_mem_t  ex_mem,
  output logic              branch_taken,
  output cpu_pkg::pc_t      branch_target
);

  cpu_pkg::word_t op_a;
  cpu_pkg::word_t op_b_reg;
  cpu_pkg::word_t op_b;
  cpu_pkg::word_t alu_y;

  //////////////////////////////
  // ID/EX register
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (stall || flush) begin
      // bubble on stall, kill on flush
      id_ex <= '0;
    end else begin
      id_ex <= id_in;
    end
  end

  function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_e sel,
                                             input cpu_pkg::word_t    reg_val,
                                             input cpu_pkg::word_t    ex_val,
                                             input cpu_pkg::word_t    wb_val);
    case (sel)
      cpu_pkg::fwd_ex_mem: return ex_val;
      cpu_pkg::fwd_mem_wb: return wb_val;
      default:             return reg_val;
    endcase
  endfunction

  assign op_a     = fwd_mux(fwd_a, id_ex.rs_data, ex_mem.alu, wb_data);
  assign op_b_reg = fwd_mux(fwd_b, id_ex.rt_data, ex_mem.alu, wb_data);
  // addi, lw and sw take the immediate
  assign op_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b_reg;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (id_ex.ctrl.alu_op)
      cpu_pkg::alu_add: alu_y = op_a + op_b;
      cpu_pkg::alu_sub: alu_y = op_a - op_b;
      cpu_pkg::alu_and: alu_y = op_a & op_b;
      cpu_pkg::alu_or:  alu_y = op_a | op_b;
      cpu_pkg::alu_xor: alu_y = op_a ^ op_b;
      cpu_pkg::alu_slt: alu_y = cpu_pkg::word_t'($signed(op_a) < $signed(op_b));
      default:          alu_y = '0;
    endcase
  end

  // compare the forwarded register values
  assign branch_taken = id_ex.ctrl.valid &&
                        ((id_ex.ctrl.beq && (op_a == op_b_reg)) ||
                         (id_ex.ctrl.bne && (op_a != op_b_reg)));
  assign branch_target = id_ex.pc_next + id_ex.imm[`CPU_IMEM_ADDR_WIDTH-1:0];

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= '{ctrl:       id_ex.ctrl,
                  alu:        alu_y,
                  store_data: op_b_reg,
                  dest:       id_ex.dest};
    end
  end

endmodule

//--- src/memory_stage.sv
`timescale 1ns/10ps

`include "cpu_cfg.svh"

module memory_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  cpu_pkg::ex_mem_t   ex_mem,
  output cpu_pkg::mem_wb_t   mem_wb,
  output cpu_pkg::word_t     wb_data,
  output cpu_pkg::wb_trace_t trace,
  output logic               halted
);

  cpu_pkg::word_t                  dmem [2**`CPU_DMEM_ADDR_WIDTH];
  cpu_pkg::word_t                  load_data;
  logic [`CPU_DMEM_ADDR_WIDTH-1:0] dmem_addr;

  // word address from the low ALU bits
  assign dmem_addr = ex_mem.alu[`CPU_DMEM_ADDR_WIDTH-1:0];
  assign load_data = dmem[dmem_addr];

  // each run starts from an all-zero data memory
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**`CPU_DMEM_ADDR_WIDTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.ctrl.valid && ex_mem.ctrl.mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  //////////////////////////////
  // MEM/WB register
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb <= '{ctrl:      ex_mem.ctrl,
                  alu:       ex_mem.alu,
                  load_data: load_data,
                  dest:      ex_mem.dest};
    end
  end

  assign wb_data = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu;

  // r0 writes are not reported
  assign trace = '{valid: mem_wb.ctrl.valid && mem_wb.ctrl.reg_write && (mem_wb.dest != '0),
                   rd:    mem_wb.dest,
                   data:  wb_data};

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted <= 1'b0;
    end else if (mem_wb.ctrl.valid && mem_wb.ctrl.halt) begin
      halted <= 1'b1;
    end
  end

  // nothing younger than the halt ever retires
  a_no_trace_after_halt: assert property (
    @(posedge clk) disable iff (!arst_n)
    trace.valid |-> !halted
  );

endmodule

//--- src/processor.sv
`timescale 1ns/10ps

`include "cpu_cfg.svh"

module processor (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               run,
  input  logic               load_we,
  input  cpu_pkg::pc_t       load_addr,
  input  cpu_pkg::word_t     load_data,
  output cpu_pkg::wb_trace_t trace,
  output logic               halted
);

  // fetch
  cpu_pkg::instr_u    if_instr;
  cpu_pkg::pc_t       if_pc_next;
  logic               if_valid;

  // decode
  cpu_pkg::ctrl_t     dec_ctrl;
  cpu_pkg::reg_addr_t dec_dest;
  cpu_pkg::word_t     rs_data;
  cpu_pkg::word_t     rt_data;
  cpu_pkg::id_ex_t    id_in;

  // hazard control
  logic               stall;
  logic               flush;
  cpu_pkg::fwd_sel_e  fwd_a;
  cpu_pkg::fwd_sel_e  fwd_b;

  // later stages
  cpu_pkg::id_ex_t    id_ex;
  cpu_pkg::ex_mem_t   ex_mem;
  cpu_pkg::mem_wb_t   mem_wb;
  cpu_pkg::word_t     wb_data;
  logic               branch_taken;
  cpu_pkg::pc_t       branch_target;

  //////////////////////////////
  // fetch
  //////////////////////////////
  fetch_stage fetch_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .run           (run),
    .load_we       (load_we),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .stall         (stall),
    .flush         (flush),
    .stop          (dec_ctrl.halt),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .instr         (if_instr),
    .pc_next       (if_pc_next),
    .instr_valid   (if_valid)
  );

  //////////////////////////////
  // decode
  //////////////////////////////
  control_unit control_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr        (if_instr),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .branch_taken (branch_taken),
    .ctrl         (dec_ctrl),
    .dest         (dec_dest),
    .stall        (stall),
    .flush        (flush),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  register_file regfile_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs      (if_instr.r.rs),
    .rt      (if_instr.r.rt),
    .wb      (mem_wb),
    .wb_data (wb_data),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  // empty IF/ID slot becomes a bubble
  assign id_in = '{ctrl:    if_valid ? dec_ctrl : '0,
                   pc_next: if_pc_next,
                   rs:      if_instr.r.rs,
                   rt:      if_instr.i.rt,
                   rs_data: rs_data,
                   rt_data: rt_data,
                   imm:     {{(`CPU_DATA_WIDTH-`CPU_IMM_WIDTH){
                                if_instr.i.imm6[`CPU_IMM_WIDTH-1]}},
                             if_instr.i.imm6},
                   dest:    dec_dest};

  //////////////////////////////
  // execute, memory, writeback
  //////////////////////////////
  execute_stage execute_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .id_in         (id_in),
    .stall         (stall),
    .flush         (flush),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .wb_data       (wb_data),
    .id_ex         (id_ex),
    .ex_mem        (ex_mem),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  memory_stage memory_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .wb_data (wb_data),
    .trace   (trace),
    .halted  (halted)
  );

endmodule

//--- bench/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// program image, shared with the load task
logic [15:0] prog [2**`CPU_IMEM_ADDR_WIDTH];
logic [2:0]  exp_rd [$];
logic [15:0] exp_data [$];

// one instruction per step, records every register write except r0
task automatic run_reference();
  logic [15:0]                    regs [8];
  logic [15:0]                    mem [2**`CPU_DMEM_ADDR_WIDTH];
  logic [15:0]                    w, a, b, imm, sum, wv;
  logic [2:0]                     wd;
  logic [`CPU_IMEM_ADDR_WIDTH-1:0] pc;
  bit                             wr;
  bit                             done;
  int                             steps;
  exp_rd.delete();
  exp_data.delete();
  foreach (regs[i]) regs[i] = '0;
  foreach (mem[i]) mem[i] = '0;
  pc    = '0;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < 4 * imem_depth) begin
    w   = prog[pc];
    a   = regs[w[11:9]];
    b   = regs[w[8:6]];
    imm = {{10{w[5]}}, w[5:0]};
    sum = a + imm;
    wr  = 1'b0;
    wd  = w[8:6];
    wv  = sum;
    pc  = pc + 1'b1;
    steps++;
    case (w[15:12])
      4'h1: begin
        wr = 1'b1;
        wd = w[5:3];
        case (w[2:0])
          3'd0: wv = a + b;
          3'd1: wv = a - b;
          3'd2: wv = a & b;
          3'd3: wv = a | b;
          3'd4: wv = a ^ b;
          3'd5: wv = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
          default: wv = '0;
        endcase
      end
      4'h2: wr = 1'b1;
      4'h3: begin
        wr = 1'b1;
        wv = mem[sum[`CPU_DMEM_ADDR_WIDTH-1:0]];
      end
      4'h4: mem[sum[`CPU_DMEM_ADDR_WIDTH-1:0]] = b;
      // pc already points past the branch
      4'h5: if (a == b) pc = pc + w[5:0];
      4'h6: if (a != b) pc = pc + w[5:0];
      4'h7: done = 1'b1;
      default: ;
    endcase
    if (wr && wd != 3'd0) begin
      regs[wd] = wv;
      exp_rd.push_back(wd);
      exp_data.push_back(wv);
    end
  end
endtask

`endif

//--- bench/processor_tb.sv
`timescale 1ns/10ps

`include "cpu_cfg.svh"

module processor_tb;

  localparam int          imem_depth  = 2**`CPU_IMEM_ADDR_WIDTH;
  localparam int          run_timeout = 2000;
  localparam logic [15:0] halt_word   = 16'h7000;

  // program styles
  localparam int mode_spread = 1;
  localparam int mode_chain  = 2;
  localparam int mode_mem    = 3;
  localparam int mode_branch = 4;
  localparam int mode_mixed  = 5;

  logic               clk;
  logic               arst_n;
  logic               run;
  logic               load_we;
  cpu_pkg::pc_t       load_addr;
  cpu_pkg::word_t     load_data;
  cpu_pkg::wb_trace_t trace;
  logic               halted;

  logic [31:0]        rng_state;
  int                 pass_count;
  int                 fail_count;
  logic [2:0]         got_rd [$];
  logic [15:0]        got_data [$];

  `include "isa_model.svh"

  processor dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .trace     (trace),
    .halted    (halted)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // r1..r3 only
  function automatic logic [2:0] small_reg(input logic [1:0] v);
    return (v == 2'd0) ? 3'd3 : {1'b0, v};
  endfunction

  //////////////////////////////
  // program generator
  //////////////////////////////
  function automatic logic [15:0] gen_word(input int mode, input int idx, input int n);
    logic [31:0] r;
    logic [2:0]  ra, rb, rc, funct;
    logic [5:0]  imm;
    logic [15:0] w;
    int          kind;
    int          off;
    r     = next_rand();
    imm   = r[30:25];
    funct = 3'(int'(r[27:25]) % 6);
    ra    = r[18:16];
    rb    = r[21:19];
    rc    = r[24:22];
    // close neighbours share registers
    if (mode >= mode_chain && mode <= mode_branch) begin
      ra = small_reg(r[17:16]);
      rb = small_reg(r[20:19]);
      rc = small_reg(r[23:22]);
    end
    case (mode)
      mode_spread: kind = (idx < 16) ? 0 : 1;
      mode_chain:  kind = int'(r[8]);
      mode_mem:    kind = int'(r[9:8]);
      mode_branch: kind = r[9] ? 4 + int'(r[8]) : int'(r[8]);
      default: begin
        kind = int'(r[10:8]);
        if (kind == 7 && r[13:11] != 3'd0) kind = 1;
      end
    endcase
    // three nops between real words, every funct in turn
    if (mode == mode_spread) begin
      if (idx % 4 != 0) kind = 6;
      rb    = (idx < 16) ? 3'(idx / 4 + 1) : rb;
      funct = 3'((idx / 4) % 6);
    end
    // forward only, never past the closing halt
    off = int'(r[26:25]);
    if (off > n - 2 - idx) off = n - 2 - idx;
    case (kind)
      0: w = {4'h2, ra, rb, imm};
      1: w = {4'h1, ra, rb, rc, funct};
      2: w = (mode == mode_mem) ? {4'h3, 3'd0, rb, 3'd0, r[27:25]} : {4'h3, ra, rb, imm};
      3: w = (mode == mode_mem) ? {4'h4, 3'd0, rb, 3'd0, r[27:25]} : {4'h4, ra, rb, imm};
      4: w = {4'h5, ra, rb, 6'(off)};
      5: w = {4'h6, ra, rb, 6'(off)};
      6: w = {r[11] ? {1'b1, r[14:12]} : 4'h0, r[27:16]};
      default: w = halt_word;
    endcase
    return w;
  endfunction

  //////////////////////////////
  // DUT handling
  //////////////////////////////
  task automatic reset_core();
    @(posedge clk);
    #1;
    arst_n  = 1'b0;
    run     = 1'b0;
    load_we = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic load_program();
    for (int a = 0; a < imem_depth; a++) begin
      @(posedge clk);
      #1;
      load_we   = 1'b1;
      load_addr = cpu_pkg::pc_t'(a);
      load_data = prog[a];
    end
    @(posedge clk);
    #1;
    load_we = 1'b0;
  endtask

  task automatic collect_trace(output bit timed_out);
    int cycles;
    got_rd.delete();
    got_data.delete();
    cycles = 0;
    while (!halted && cycles < run_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
      if (trace.valid) begin
        got_rd.push_back(trace.rd);
        got_data.push_back(trace.data);
      end
    end
    timed_out = !halted;
  endtask

  task automatic compare_trace(input string name, inout bit ok);
    if (got_rd.size() != exp_rd.size()) begin
      $display("%s: core wrote %0d registers but the model expects %0d",
               name, got_rd.size(), exp_rd.size());
      ok = 1'b0;
    end
    for (int i = 0; i < got_rd.size() && i < exp_rd.size(); i++) begin
      if (got_rd[i] != exp_rd[i] || got_data[i] != exp_data[i]) begin
        $display("FAILED %s entry %0d: expected {rd %0d, data %h} actual {rd %0d, data %h}",
                 name, i, exp_rd[i], exp_data[i], got_rd[i], got_data[i]);
        ok = 1'b0;
      end
    end
  endtask

  // load prog, start the core and check the whole trace
  task automatic execute_and_check(input string name, inout bit ok);
    bit timed_out;
    load_program();
    run = 1'b1;
    collect_trace(timed_out);
    if (timed_out) begin
      $display("%s: halted did not rise within %0d cycles", name, run_timeout);
      ok = 1'b0;
    end else begin
      compare_trace(name, ok);
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: FAIL", name);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic idle_and_halt_test();
    bit ok;
    ok = 1'b1;
    reset_core();
    for (int c = 0; c < 20; c++) begin
      @(posedge clk);
      #1;
      if (trace.valid || halted) begin
        $display("idle_halt: trace or halted active before run, cycle %0d", c);
        ok = 1'b0;
      end
    end
    foreach (prog[a]) prog[a] = halt_word;
    run_reference();
    execute_and_check("idle_halt", ok);
    report_test("idle_halt", ok);
  endtask

  task automatic random_program_test(input string name, input int mode);
    logic [31:0] r;
    int          n;
    bit          ok;
    r  = next_rand();
    // spread programs are long enough to reach every ALU operation
    n  = (mode == mode_spread) ? 60 : 20 + int'(r % 41);
    ok = 1'b1;
    // the tail stays halt so stray fetches stop cleanly
    for (int a = 0; a < imem_depth; a++) begin
      prog[a] = (a < n - 1) ? gen_word(mode, a, n) : halt_word;
    end
    run_reference();
    reset_core();
    execute_and_check(name, ok);
    report_test(name, ok);
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    run        = 1'b0;
    load_we    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    rng_state  = 32'd93720;
    pass_count = 0;
    fail_count = 0;

    idle_and_halt_test();
    for (int t = 0; t < 3; t++) random_program_test($sformatf("alu_spread_%0d", t), mode_spread);
    for (int t = 0; t < 4; t++) random_program_test($sformatf("dep_chain_%0d", t), mode_chain);
    for (int t = 0; t < 4; t++) random_program_test($sformatf("load_store_%0d", t), mode_mem);
    for (int t = 0; t < 6; t++) random_program_test($sformatf("branch_%0d", t), mode_branch);
    for (int t = 0; t < 30; t++) random_program_test($sformatf("mixed_%0d", t), mode_mixed);

    $display("summary: %0d run, %0d passed, %0d failed",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+src
+incdir+bench
src/cpu_pkg.sv
src/control_unit.sv
src/fetch_stage.sv
src/register_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/processor.sv
bench/processor_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = processor_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = tests failed
PASS_MSG = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
